/* verilog/stepper_pkg.sv */
`default_nettype none

package stepper_pkg;

  // cosine table shape, entry i sits at bits 8i+7:8i of the table port
  localparam int COS_ENTRIES = 64;
  localparam int COS_BITS    = 8;

  // chopper settings, common to both coils
  typedef struct packed {
    logic [9:0] off_time;            // cycles the off timer runs after a trip
    logic [7:0] blank_time;          // comparator ignored this long after a polarity change
    logic [9:0] fastdecay_threshold; // off timer at or above this means fast decay
    logic [7:0] min_on_time;         // a trip before this expires is a short
  } chop_cfg_t;

  // demand for one coil as produced by the sequencer
  typedef struct packed {
    logic [5:0] index;    // cosine table entry
    logic       negative; // current flows from the second half-bridge to the first
  } coil_cmd_t;

  // bridge mode of one coil
  typedef enum logic [1:0] {
    DECAY_DRIVE = 2'd0,
    DECAY_FAST  = 2'd1,
    DECAY_SLOW  = 2'd2
  } decay_t;

endpackage

`default_nettype wire

/* verilog/step_sequencer.sv */
`timescale 1ns/100ps
`default_nettype none

module step_sequencer (
  input  logic                  clk,
  input  logic                  resetn,
  input  logic                  step,
  input  logic                  dir,
  output stepper_pkg::coil_cmd_t cmd_a,
  output stepper_pkg::coil_cmd_t cmd_b
);

  logic [7:0] phase;
  logic [7:0] phase_b;

  // one electrical period is 256 microsteps in four quadrants of 64
  function automatic stepper_pkg::coil_cmd_t decode(logic [7:0] ph);
    stepper_pkg::coil_cmd_t c;
    logic [5:0] ofs;
    ofs = ph[5:0];
    // odd quadrants walk the table backwards
    c.index = ph[6] ? ~ofs : ofs;
    // quadrants 1 and 2 carry negative current
    c.negative = ph[7] ^ ph[6];
    return c;
  endfunction

  // coil b lags coil a by a quarter period
  assign phase_b = phase - 8'd64;

  always_ff @(posedge clk) begin
    if (!resetn) begin
      phase <= 8'd0;
    end else if (step) begin
      phase <= dir ? phase + 8'd1 : phase - 8'd1;
    end
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      cmd_a <= '0;
      cmd_b <= '0;
    end else begin
      cmd_a <= decode(phase);
      cmd_b <= decode(phase_b);
    end
  end

endmodule

`default_nettype wire

/* verilog/current_reference.sv */
`timescale 1ns/100ps
`default_nettype none

module current_reference #(
  parameter int PWM_BITS = 8 // at least COS_BITS
) (
  input  logic                                                    clk,
  input  logic                                                    resetn,
  input  stepper_pkg::coil_cmd_t                                  cmd,
  input  logic [7:0]                                              current_scale,
  input  logic [stepper_pkg::COS_ENTRIES*stepper_pkg::COS_BITS-1:0] cos_table,
  output logic                                                    ref_out
);

  logic [stepper_pkg::COS_BITS-1:0]   entry;
  logic [stepper_pkg::COS_BITS+7:0]   product;
  logic [stepper_pkg::COS_BITS-1:0]   level;
  logic [PWM_BITS-1:0]                duty;
  logic [PWM_BITS-1:0]                pwm_cnt;

  assign entry   = cos_table[cmd.index*stepper_pkg::COS_BITS +: stepper_pkg::COS_BITS];
  assign product = entry * current_scale;

  always_ff @(posedge clk) begin
    if (!resetn) begin
      level <= '0;
    end else begin
      level <= product[stepper_pkg::COS_BITS+7:8]; // divide by 256
    end
  end

  // free-running, one reference period every 2**PWM_BITS cycles
  always_ff @(posedge clk) begin
    if (!resetn) begin
      pwm_cnt <= '0;
    end else begin
      pwm_cnt <= pwm_cnt + 1'b1;
    end
  end

  // wider counters keep the same duty ratio
  assign duty    = PWM_BITS'(level) << (PWM_BITS - stepper_pkg::COS_BITS);
  assign ref_out = pwm_cnt < duty;

  // scaling only ever attenuates the table value
  assert property (@(posedge clk) disable iff (!resetn)
    level <= $past(entry))
    else $error("reference level above its table entry");

endmodule

`default_nettype wire

/* verilog/coil_chopper.sv */
`timescale 1ns/100ps
`default_nettype none

module coil_chopper (
  input  logic                   clk,
  input  logic                   resetn,
  input  logic                   cmp,
  input  stepper_pkg::coil_cmd_t cmd,
  input  stepper_pkg::chop_cfg_t cfg,
  output stepper_pkg::decay_t    mode,
  output logic                   fault_event
);

  logic       cmp_meta;
  logic       cmp_sync;
  logic       neg_prev;
  logic       pol_change;
  logic       load_off;
  logic [7:0] blank_timer;
  logic [7:0] min_on_timer;
  logic [9:0] off_timer;

  // comparator is asynchronous to clk
  always_ff @(posedge clk) begin
    if (!resetn) begin
      cmp_meta <= 1'b0;
      cmp_sync <= 1'b0;
    end else begin
      cmp_meta <= cmp;
      cmp_sync <= cmp_meta;
    end
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      neg_prev <= 1'b0;
    end else begin
      neg_prev <= cmd.negative;
    end
  end

  // the bridge swaps sides and the current ringing that follows is not a trip
  assign pol_change = cmd.negative != neg_prev;

  assign load_off = cmp_sync && blank_timer == 8'd0 && off_timer == 10'd0;

  always_ff @(posedge clk) begin
    if (!resetn) begin
      blank_timer <= 8'd0;
    end else if (pol_change) begin
      blank_timer <= cfg.blank_time;
    end else if (blank_timer != 8'd0) begin
      blank_timer <= blank_timer - 8'd1;
    end
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      min_on_timer <= 8'd0;
    end else if (pol_change) begin
      min_on_timer <= cfg.min_on_time;
    end else if (min_on_timer != 8'd0) begin
      min_on_timer <= min_on_timer - 8'd1;
    end
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      off_timer <= 10'd0;
    end else if (load_off) begin
      off_timer <= cfg.off_time;
    end else if (off_timer != 10'd0) begin
      off_timer <= off_timer - 10'd1;
    end
  end

  // fast decay first to pull the current down quickly, then slow decay
  always_comb begin
    if (off_timer == 10'd0) begin
      mode = stepper_pkg::DECAY_DRIVE;
    end else if (off_timer >= cfg.fastdecay_threshold) begin
      mode = stepper_pkg::DECAY_FAST;
    end else begin
      mode = stepper_pkg::DECAY_SLOW;
    end
  end

  // current reached the trip level too soon after switching on, so the
  // winding or the bridge is shorted
  assign fault_event = load_off && min_on_timer != 8'd0;

  assert property (@(posedge clk) disable iff (!resetn)
    $rose(off_timer != 10'd0) |-> $past(blank_timer == 8'd0 && cmp_sync))
    else $error("off timer started while blanking");

endmodule

`default_nettype wire

/* verilog/bridge_gate.sv */
`timescale 1ns/100ps
`default_nettype none

module bridge_gate #(
  parameter int CP_DIV = 4
) (
  input  logic                clk,
  input  logic                resetn,
  input  logic                enable,
  input  logic                fault_event_a,
  input  logic                fault_event_b,
  input  stepper_pkg::decay_t mode_a,
  input  stepper_pkg::decay_t mode_b,
  input  logic                neg_a,
  input  logic                neg_b,
  output logic [3:0]          gate_h,
  output logic [3:0]          gate_l,
  output logic                chargepump_pin
);

  logic              fault;
  logic              enable_r;
  logic [3:0]        pat_a;
  logic [3:0]        pat_b;
  logic [CP_DIV-1:0] cp_cnt;

  // returns {high[1:0], low[1:0]} for the two half-bridges of one coil
  function automatic logic [3:0] coil_gates(stepper_pkg::decay_t m, logic neg);
    logic fwd; // first half-bridge sources the current
    logic [3:0] g;
    fwd = (m == stepper_pkg::DECAY_FAST) ? neg : ~neg;
    case (m)
      stepper_pkg::DECAY_DRIVE,
      stepper_pkg::DECAY_FAST: g = {~fwd, fwd, fwd, ~fwd};
      stepper_pkg::DECAY_SLOW: g = 4'b0011; // both low sides on so the current recirculates
      default:                 g = 4'b0000;
    endcase
    return g;
  endfunction

  assign pat_a = coil_gates(mode_a, neg_a);
  assign pat_b = coil_gates(mode_b, neg_b);

  // held until the next reset
  always_ff @(posedge clk) begin
    if (!resetn) begin
      fault <= 1'b0;
    end else if (fault_event_a || fault_event_b) begin
      fault <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      enable_r <= 1'b0;
    end else begin
      enable_r <= enable;
    end
  end

  always_ff @(posedge clk) begin
    if (!resetn || fault || !enable_r) begin
      gate_h <= 4'b0000;
      gate_l <= 4'b0000;
    end else begin
      gate_h <= {pat_b[3:2], pat_a[3:2]};
      gate_l <= {pat_b[1:0], pat_a[1:0]};
    end
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      cp_cnt         <= '0;
      chargepump_pin <= 1'b0;
    end else begin
      cp_cnt <= cp_cnt + 1'b1;
      if (&cp_cnt) chargepump_pin <= ~chargepump_pin; // toggle on wrap
    end
  end

  assert property (@(posedge clk) (gate_h & gate_l) == 4'b0000)
    else $error("shoot-through on a half-bridge");

endmodule

`default_nettype wire

/* verilog/microstepper_top.sv */
`timescale 1ns/100ps
`default_nettype none

module microstepper_top #(
  parameter int CP_DIV   = 4,
  parameter int PWM_BITS = 8
) (
  input  logic                                                    clk,
  input  logic                                                    resetn,
  input  logic                                                    step,
  input  logic                                                    dir,
  input  logic                                                    enable,
  input  stepper_pkg::chop_cfg_t                                  cfg,
  input  logic [7:0]                                              current_scale,
  input  logic [stepper_pkg::COS_ENTRIES*stepper_pkg::COS_BITS-1:0] cos_table,
  input  logic                                                    cmp_a,
  input  logic                                                    cmp_b,
  output logic                                                    ref_a,
  output logic                                                    ref_b,
  output logic [3:0]                                              gate_h,
  output logic [3:0]                                              gate_l,
  output logic                                                    chargepump_pin
);

  stepper_pkg::coil_cmd_t cmd_a;
  stepper_pkg::coil_cmd_t cmd_b;
  stepper_pkg::decay_t    mode_a;
  stepper_pkg::decay_t    mode_b;
  logic                   fault_event_a;
  logic                   fault_event_b;

  step_sequencer seq0 (
    .clk    (clk),
    .resetn (resetn),
    .step   (step),
    .dir    (dir),
    .cmd_a  (cmd_a),
    .cmd_b  (cmd_b)
  );

  current_reference #(.PWM_BITS(PWM_BITS)) ref_a0 (
    .clk           (clk),
    .resetn        (resetn),
    .cmd           (cmd_a),
    .current_scale (current_scale),
    .cos_table     (cos_table),
    .ref_out       (ref_a)
  );

  current_reference #(.PWM_BITS(PWM_BITS)) ref_b0 (
    .clk           (clk),
    .resetn        (resetn),
    .cmd           (cmd_b),
    .current_scale (current_scale),
    .cos_table     (cos_table),
    .ref_out       (ref_b)
  );

  coil_chopper chop_a0 (
    .clk         (clk),
    .resetn      (resetn),
    .cmp         (cmp_a),
    .cmd         (cmd_a),
    .cfg         (cfg),
    .mode        (mode_a),
    .fault_event (fault_event_a)
  );

  coil_chopper chop_b0 (
    .clk         (clk),
    .resetn      (resetn),
    .cmp         (cmp_b),
    .cmd         (cmd_b),
    .cfg         (cfg),
    .mode        (mode_b),
    .fault_event (fault_event_b)
  );

  bridge_gate #(.CP_DIV(CP_DIV)) gate0 (
    .clk            (clk),
    .resetn         (resetn),
    .enable         (enable),
    .fault_event_a  (fault_event_a),
    .fault_event_b  (fault_event_b),
    .mode_a         (mode_a),
    .mode_b         (mode_b),
    .neg_a          (cmd_a.negative),
    .neg_b          (cmd_b.negative),
    .gate_h         (gate_h),
    .gate_l         (gate_l),
    .chargepump_pin (chargepump_pin)
  );

endmodule

`default_nettype wire

/* tests/coil_model.sv */
`timescale 1ns/100ps
`default_nettype none

module coil_model (
  input  logic       clk,
  input  logic       resetn,
  input  logic [1:0] gate_h,  // high sides of the two half-bridges of this coil
  input  logic [1:0] gate_l,
  input  logic       neg,     // sign the coil is meant to be driven with
  input  int         limit,   // trip level of the comparator
  output logic       cmp
);

  int  current;
  logic driving;

  // positive drive sources from the first half-bridge and sinks into the second
  assign driving = neg ? (gate_h == 2'b10 && gate_l == 2'b01)
                       : (gate_h == 2'b01 && gate_l == 2'b10);

  always_ff @(posedge clk) begin
    if (!resetn) begin
      current <= 0;
    end else if (driving) begin
      current <= current + 1;
    end else if (current > 0) begin
      current <= current - 1; // decay, fast or slow alike
    end
  end

  assign cmp = current >= limit;

endmodule

`default_nettype wire

/* tests/microstepper_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module microstepper_tb;

  localparam int TIMEOUT = 20000;
  localparam int OUT_OF_REACH = 32'h7fffffff;

  logic clk = 1'b0;
  logic resetn, step, dir, enable, cmp_a, cmp_b;
  stepper_pkg::chop_cfg_t cfg;
  logic [7:0] current_scale;
  logic [511:0] cos_table;
  logic ref_a, ref_b, chargepump_pin;
  logic [3:0] gate_h, gate_l;
  logic [7:0] cos_mem [64];
  logic [7:0] phase; // phase as counted from the strobes sent
  int limit_a, limit_b, errors, checks, cycles, seed;

  microstepper_top #(.CP_DIV(4), .PWM_BITS(8)) dut0 (
    .clk(clk), .resetn(resetn), .step(step), .dir(dir), .enable(enable), .cfg(cfg),
    .current_scale(current_scale), .cos_table(cos_table), .cmp_a(cmp_a), .cmp_b(cmp_b),
    .ref_a(ref_a), .ref_b(ref_b), .gate_h(gate_h), .gate_l(gate_l),
    .chargepump_pin(chargepump_pin)
  );

  coil_model coil_a0 (.clk(clk), .resetn(resetn), .gate_h(gate_h[1:0]), .gate_l(gate_l[1:0]),
    .neg(coil_neg(phase)), .limit(limit_a), .cmp(cmp_a));
  coil_model coil_b0 (.clk(clk), .resetn(resetn), .gate_h(gate_h[3:2]), .gate_l(gate_l[3:2]),
    .neg(coil_neg(phase - 8'd64)), .limit(limit_b), .cmp(cmp_b));

  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT) begin
      $display("timeout: the run did not finish within %0d cycles", TIMEOUT);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  // quadrants 1 and 2 carry negative current
  function automatic logic coil_neg(logic [7:0] ph);
    return ph[7:6] == 2'd1 || ph[7:6] == 2'd2;
  endfunction

  function automatic int coil_index(logic [7:0] ph);
    return (ph[7:6] == 2'd1 || ph[7:6] == 2'd3) ? 63 - ph[5:0] : ph[5:0];
  endfunction

  // {high1, high0, low1, low0} of one coil
  function automatic logic [3:0] drive_gates(logic neg);
    return neg ? 4'b1001 : 4'b0110;
  endfunction

  function automatic int scaled_level(logic [7:0] ph);
    return (cos_mem[coil_index(ph)] * current_scale) / 256;
  endfunction

  assert property (@(posedge clk) cycles > 1 |-> (gate_h & gate_l) == 4'b0000)
    else begin
      errors++;
      $display("ERROR %0t: both gates of a half-bridge on", $time);
    end

  assert property (@(posedge clk) (cycles > 1 && !$past(resetn)) |->
      (gate_h == 4'b0 && gate_l == 4'b0 && !ref_a && !ref_b))
    else begin
      errors++;
      $display("ERROR %0t: outputs active in reset", $time);
    end

  task automatic apply_reset();
    @(negedge clk);
    resetn = 1'b0;
    phase = 8'd0;
    repeat (10) @(negedge clk);
    resetn = 1'b1;
  endtask

  task automatic send_steps(int n, logic up);
    repeat (n) begin
      @(negedge clk);
      step = 1'b1;
      dir = up;
      phase = up ? phase + 8'd1 : phase - 8'd1;
    end
    @(negedge clk);
    step = 1'b0;
  endtask

  // checks one full PWM period of both references and then the drive pattern of both coils
  task automatic check_position();
    int high_a, high_b;
    high_a = 0;
    high_b = 0;
    repeat (2) @(negedge clk);
    repeat (256) begin
      high_a += ref_a;
      high_b += ref_b;
      @(negedge clk);
    end
    checks += 4;
    assert (high_a == scaled_level(phase) && high_b == scaled_level(phase - 8'd64))
      else begin
        errors++;
        $display("ERROR %0t: phase %0d duty a %0d b %0d", $time, phase, high_a, high_b);
      end
    assert ({gate_h[1:0], gate_l[1:0]} == drive_gates(coil_neg(phase)) &&
            {gate_h[3:2], gate_l[3:2]} == drive_gates(coil_neg(phase - 8'd64)))
      else begin
        errors++;
        $display("ERROR %0t: wrong drive pattern at phase %0d", $time, phase);
      end
  endtask

  task automatic expect_coil_a(logic [3:0] pattern, int n, string what);
    repeat (n) begin
      @(negedge clk);
      checks++;
      assert ({gate_h[1:0], gate_l[1:0]} == pattern)
        else begin
          errors++;
          $display("ERROR %0t: coil a not in %s", $time, what);
        end
    end
  endtask

  initial begin
    int t;
    seed = 62071;
    for (int i = 0; i < 64; i++) begin
      t = $random(seed);
      cos_mem[i] = t[7:0];
      cos_table[i*8 +: 8] = t[7:0];
    end
    {errors, checks, cycles} = '0;
    {step, dir, enable} = 3'b000;
    resetn = 1'b0;
    current_scale = 8'd200;
    cfg.off_time = 10'd40;
    cfg.blank_time = 8'd10;
    cfg.fastdecay_threshold = 10'd20;
    cfg.min_on_time = 8'd30;
    limit_a = OUT_OF_REACH;
    limit_b = OUT_OF_REACH;
    apply_reset();

    // charge pump half period is 2**CP_DIV cycles
    @(posedge chargepump_pin);
    @(negedge clk);
    t = 0;
    while (chargepump_pin == 1'b1) begin
      t++;
      @(negedge clk);
    end
    checks++;
    assert (t == 16)
      else begin
        errors++;
        $display("ERROR %0t: charge pump %0d", $time, t);
      end

    enable = 1'b1;
    send_steps(40, 1'b1);
    check_position();
    send_steps(50, 1'b1);
    check_position();
    send_steps(80, 1'b1);
    check_position();
    send_steps(30, 1'b0);
    check_position();
    send_steps(90, 1'b1);
    check_position();
    send_steps(240, 1'b0);
    check_position();

    // trip the comparator of coil a for one cycle
    @(negedge clk);
    limit_a = 0;
    @(negedge clk);
    limit_a = OUT_OF_REACH;
    repeat (2) @(negedge clk);
    expect_coil_a(~drive_gates(coil_neg(phase)), 21, "fast decay");
    expect_coil_a(4'b0011, 19, "slow decay");
    expect_coil_a(drive_gates(coil_neg(phase)), 1, "drive");

    enable = 1'b0;
    repeat (2) @(negedge clk);
    checks++;
    assert (gate_h == 4'b0 && gate_l == 4'b0)
      else begin
        errors++;
        $display("ERROR %0t: gates on with enable low", $time);
      end
    enable = 1'b1;

    // coil a changes sign on the step from 63 to 64
    apply_reset();
    send_steps(63, 1'b1);
    repeat (60) @(negedge clk);
    send_steps(1, 1'b1);
    repeat (2) @(negedge clk);
    limit_a = 0; // high only while blanking
    repeat (3) @(negedge clk);
    limit_a = OUT_OF_REACH;
    expect_coil_a(drive_gates(1'b1), 18, "drive after a blanked trip");
    limit_a = 0; // blanking is over but the minimum on time still runs
    repeat (3) @(negedge clk);
    limit_a = OUT_OF_REACH;
    repeat (40) begin
      @(negedge clk);
      checks++;
      assert (gate_h == 4'b0 && gate_l == 4'b0)
        else begin
          errors++;
          $display("ERROR %0t: gates on after a fault", $time);
        end
    end

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
verilog/stepper_pkg.sv
verilog/step_sequencer.sv
verilog/current_reference.sv
verilog/coil_chopper.sv
verilog/bridge_gate.sv
verilog/microstepper_top.sv
tests/coil_model.sv
tests/microstepper_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the testbench, pass only when the pass message shows up
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module microstepper_tb \
  -f verilog.f -o microstepper_sim &&
./obj_dir/microstepper_sim | tee /dev/stderr | grep -q "TESTBENCH PASSED" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
